//--- common/ahb_pkg.sv
package ahb_pkg;

  // ******************************
  // Bus field types
  // ******************************
  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [15:0] gpio_t;

  // Transfer type, only NONSEQ and SEQ carry a transfer
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_t;

  // Data-phase target index
  typedef enum logic [1:0] {
    SLV_SRAM  = 2'd0,
    SLV_GPIO  = 2'd1,
    SLV_NOMAP = 2'd2
  } slave_idx_t;

  // ******************************
  // Address map
  // ******************************
  localparam haddr_t SRAM_BASE  = 32'h0000_0000;
  localparam haddr_t SRAM_LIMIT = 32'h0000_FFFF;
  localparam haddr_t GPIO_BASE  = 32'h4000_0000;

  // GPIO register offsets inside the 4 KB window
  localparam logic [11:0] GPIO_DATA_OUT_OFS = 12'h000;
  localparam logic [11:0] GPIO_OUT_EN_OFS   = 12'h004;
  localparam logic [11:0] GPIO_DATA_IN_OFS  = 12'h008;

  // Little-endian byte lanes touched by a transfer
  function automatic logic [3:0] byte_lanes(hsize_t size, logic [1:0] addr);
    case (size)
      HSIZE_BYTE: return 4'b0001 << addr;
      HSIZE_HALF: return addr[1] ? 4'b1100 : 4'b0011;
      default:    return 4'b1111;
    endcase
  endfunction

endpackage

//--- common/ahb_if.sv
`timescale 1ns/1ps

interface ahb_if import ahb_pkg::*; ();

  // Address phase, driven from the top-level ports
  haddr_t  haddr;
  htrans_t htrans;
  logic    hwrite;
  hsize_t  hsize;

  // Write data, one cycle after its address phase
  hdata_t  hwdata;

  // Multiplexed ready from the response mux
  logic    hready;

  // Master side, top level and response mux
  modport master (
    output haddr,
    output htrans,
    output hwrite,
    output hsize,
    output hwdata,
    output hready
  );

  // Slave side, read only
  modport slave (
    input haddr,
    input htrans,
    input hwrite,
    input hsize,
    input hwdata,
    input hready
  );

endinterface

//--- logic/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder import ahb_pkg::*; (
  ahb_if.slave       bus,
  output logic       hsel_sram,
  output logic       hsel_gpio,
  output logic       hsel_nomap,
  output slave_idx_t slave_idx
);

  // SRAM window, 64 KB at the bottom of the map
  assign hsel_sram = (bus.haddr >= SRAM_BASE) && (bus.haddr <= SRAM_LIMIT);

  // GPIO window, 4 KB page
  assign hsel_gpio = (bus.haddr[31:12] == GPIO_BASE[31:12]);

  // Everything else falls through to nomap
  assign hsel_nomap = !hsel_sram && !hsel_gpio;

  // Index for the response mux
  always_comb begin
    if (hsel_sram) begin
      slave_idx = SLV_SRAM;
    end else if (hsel_gpio) begin
      slave_idx = SLV_GPIO;
    end else begin
      slave_idx = SLV_NOMAP;
    end
  end

endmodule

//--- logic/ahb_resp_mux.sv
`timescale 1ns/1ps

module ahb_resp_mux import ahb_pkg::*; (
  input  logic       fclk,
  input  logic       hresetn,
  ahb_if.master      bus,
  input  slave_idx_t slave_idx,
  input  logic       hreadyout_sram,
  input  logic       hreadyout_gpio,
  input  hdata_t     hrdata_sram,
  input  hdata_t     hrdata_gpio,
  output hdata_t     hrdata
);

  // Target of the transfer now in its data phase
  slave_idx_t data_idx;

  // Advance only when the current data phase ends
  always_ff @(posedge fclk or negedge hresetn) begin
    if (!hresetn) begin
      data_idx <= SLV_NOMAP;
    end else if (bus.hready) begin
      data_idx <= slave_idx;
    end
  end

  // ******************************
  // Response select
  // ******************************
  always_comb begin
    case (data_idx)
      SLV_SRAM: begin
        bus.hready = hreadyout_sram;
        hrdata     = hrdata_sram;
      end
      SLV_GPIO: begin
        bus.hready = hreadyout_gpio;
        hrdata     = hrdata_gpio;
      end
      default: begin
        // No-map target, ready at once, reads as zero
        bus.hready = 1'b1;
        hrdata     = '0;
      end
    endcase
  end

endmodule

//--- sram/ahb_sram_bridge.sv
`timescale 1ns/1ps

module ahb_sram_bridge import ahb_pkg::*; #(
  parameter int SRAM_ADDR_W = 10
) (
  input  logic                   fclk,
  input  logic                   hresetn,
  ahb_if.slave                   bus,
  input  logic                   hsel,
  output logic                   hreadyout,
  output hdata_t                 hrdata,
  output logic [SRAM_ADDR_W-1:0] sram_addr,
  output logic [3:0]             sram_wen,
  output hdata_t                 sram_wdata,
  output logic                   sram_cs,
  input  hdata_t                 sram_rdata
);

  logic                   accept;
  logic                   rd_access;
  logic                   commit;
  // Data-phase state
  logic                   dp_read;
  logic                   dp_write;
  logic                   rd_done;
  logic [SRAM_ADDR_W-1:0] dp_addr;
  logic [3:0]             dp_strb;
  // One-entry write buffer
  logic                   buf_valid;
  logic [SRAM_ADDR_W-1:0] buf_addr;
  logic [3:0]             buf_strb;
  hdata_t                 buf_data;
  // Lanes taken from the buffer on a read hit
  logic [3:0]             fwd_strb;

  assign accept = hsel && bus.hready && (bus.htrans inside {HTRANS_NONSEQ, HTRANS_SEQ});

  // First data cycle of a read owns the memory port
  assign rd_access = dp_read && !rd_done;
  // Buffered write drains whenever the port is free
  assign commit    = buf_valid && !rd_access;
  // One wait state per read
  assign hreadyout = !rd_access;

  always_ff @(posedge fclk or negedge hresetn) begin
    if (!hresetn) begin
      dp_read   <= 1'b0;
      dp_write  <= 1'b0;
      rd_done   <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      if (bus.hready) begin
        dp_read  <= accept && !bus.hwrite;
        dp_write <= accept && bus.hwrite;
      end
      if (rd_access) begin
        rd_done <= 1'b1;
      end else if (bus.hready) begin
        rd_done <= 1'b0;
      end
      // Write data lands in the buffer at the end of its data phase
      if (dp_write && bus.hready) begin
        buf_valid <= 1'b1;
      end else if (commit) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (accept) begin
      // Word address, upper bits alias
      dp_addr <= bus.haddr[SRAM_ADDR_W+1:2];
      dp_strb <= byte_lanes(bus.hsize, bus.haddr[1:0]);
    end
    if (dp_write && bus.hready) begin
      buf_addr <= dp_addr;
      buf_strb <= dp_strb;
      buf_data <= bus.hwdata;
    end
    // Hit check against a still pending write
    if (rd_access) begin
      fwd_strb <= (buf_valid && (buf_addr == dp_addr)) ? buf_strb : 4'b0000;
    end
  end

  // ******************************
  // Memory port
  // ******************************
  assign sram_cs    = rd_access || commit;
  assign sram_addr  = rd_access ? dp_addr : buf_addr;
  assign sram_wen   = commit ? buf_strb : 4'b0000;
  assign sram_wdata = buf_data;

  // Merge forwarded lanes over memory data
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      hrdata[8*i +: 8] = fwd_strb[i] ? buf_data[8*i +: 8] : sram_rdata[8*i +: 8];
    end
  end

endmodule

//--- sram/sram_bank.sv
`timescale 1ns/1ps

module sram_bank import ahb_pkg::*; #(
  parameter int SRAM_ADDR_W = 10
) (
  input  logic                   fclk,
  input  logic [SRAM_ADDR_W-1:0] addr,
  input  logic [3:0]             wen,
  input  logic                   cs,
  input  hdata_t                 wdata,
  output hdata_t                 rdata
);

  // Word array, contents kept across soft reset
  hdata_t mem [0:(2**SRAM_ADDR_W)-1];

  always_ff @(posedge fclk) begin
    if (cs) begin
      // Per-lane writes
      for (int i = 0; i < 4; i++) begin
        if (wen[i]) begin
          mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
      // Registered read, old data on a write
      rdata <= mem[addr];
    end
  end

endmodule

//--- gpio/ahb_gpio.sv
`timescale 1ns/1ps

module ahb_gpio import ahb_pkg::*; (
  input  logic   fclk,
  input  logic   hresetn,
  ahb_if.slave   bus,
  input  logic   hsel,
  output logic   hreadyout,
  output hdata_t hrdata,
  input  gpio_t  gpio_in,
  output gpio_t  gpio_out,
  output gpio_t  gpio_oe
);

  logic       accept;
  logic       dp_write;
  logic [9:0] dp_word;
  logic [3:0] dp_strb;
  gpio_t      data_out;
  gpio_t      out_en;
  gpio_t      in_meta;
  gpio_t      in_sync;

  assign accept = hsel && bus.hready && (bus.htrans inside {HTRANS_NONSEQ, HTRANS_SEQ});

  // Register block never stalls
  assign hreadyout = 1'b1;

  // Address phase capture, word offset only
  always_ff @(posedge fclk) begin
    if (accept) begin
      dp_word <= bus.haddr[11:2];
      dp_strb <= byte_lanes(bus.hsize, bus.haddr[1:0]);
    end
  end

  // ******************************
  // Registers
  // ******************************
  always_ff @(posedge fclk or negedge hresetn) begin
    if (!hresetn) begin
      dp_write <= 1'b0;
      data_out <= '0;
      out_en   <= '0;
      in_meta  <= '0;
      in_sync  <= '0;
    end else begin
      if (bus.hready) begin
        dp_write <= accept && bus.hwrite;
      end
      // Two-flop input sync
      in_meta <= gpio_in;
      in_sync <= in_meta;
      // Write lands at end of data phase, low two lanes only
      if (dp_write && bus.hready) begin
        if (dp_word == GPIO_DATA_OUT_OFS[11:2]) begin
          if (dp_strb[0]) data_out[7:0]  <= bus.hwdata[7:0];
          if (dp_strb[1]) data_out[15:8] <= bus.hwdata[15:8];
        end
        if (dp_word == GPIO_OUT_EN_OFS[11:2]) begin
          if (dp_strb[0]) out_en[7:0]  <= bus.hwdata[7:0];
          if (dp_strb[1]) out_en[15:8] <= bus.hwdata[15:8];
        end
      end
    end
  end

  // Read mux, zero extended
  always_comb begin
    case (dp_word)
      GPIO_DATA_OUT_OFS[11:2]: hrdata = {16'h0000, data_out};
      GPIO_OUT_EN_OFS[11:2]:   hrdata = {16'h0000, out_en};
      GPIO_DATA_IN_OFS[11:2]:  hrdata = {16'h0000, in_sync};
      default:                 hrdata = '0;
    endcase
  end

  assign gpio_out = data_out;
  assign gpio_oe  = out_en;

endmodule

//--- logic/ahb_subsystem.sv
`timescale 1ns/1ps

module ahb_subsystem import ahb_pkg::*; #(
  parameter int SRAM_ADDR_W = 10
) (
  input  logic    fclk,
  input  logic    resetn,
  input  logic    soft_reset_req,
  input  haddr_t  haddr,
  input  htrans_t htrans,
  input  logic    hwrite,
  input  hsize_t  hsize,
  input  hdata_t  hwdata,
  output hdata_t  hrdata,
  output logic    hready,
  input  gpio_t   gpio_in,
  output gpio_t   gpio_out,
  output gpio_t   gpio_oe
);

  logic [1:0]             rst_sync;
  logic                   hresetn;
  logic                   hsel_sram;
  logic                   hsel_gpio;
  slave_idx_t             slave_idx;
  logic                   hreadyout_sram;
  logic                   hreadyout_gpio;
  hdata_t                 hrdata_sram;
  hdata_t                 hrdata_gpio;
  logic [SRAM_ADDR_W-1:0] sram_addr;
  logic [3:0]             sram_wen;
  hdata_t                 sram_wdata;
  logic                   sram_cs;
  hdata_t                 sram_rdata;

  // ******************************
  // Reset synchronizer
  // ******************************
  // Three flops, last stage also takes the soft reset
  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      rst_sync <= 2'b00;
      hresetn  <= 1'b0;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
      hresetn  <= rst_sync[1] && !soft_reset_req;
    end
  end

  // Shared bus from the master ports
  ahb_if bus ();

  assign bus.haddr  = haddr;
  assign bus.htrans = htrans;
  assign bus.hwrite = hwrite;
  assign bus.hsize  = hsize;
  assign bus.hwdata = hwdata;
  assign hready     = bus.hready;

  // Nomap select is carried by slave_idx
  ahb_decoder u_decoder (
    .bus        (bus),
    .hsel_sram  (hsel_sram),
    .hsel_gpio  (hsel_gpio),
    .hsel_nomap (),
    .slave_idx  (slave_idx)
  );

  ahb_resp_mux u_resp_mux (
    .fclk           (fclk),
    .hresetn        (hresetn),
    .bus            (bus),
    .slave_idx      (slave_idx),
    .hreadyout_sram (hreadyout_sram),
    .hreadyout_gpio (hreadyout_gpio),
    .hrdata_sram    (hrdata_sram),
    .hrdata_gpio    (hrdata_gpio),
    .hrdata         (hrdata)
  );

  ahb_sram_bridge #(.SRAM_ADDR_W(SRAM_ADDR_W)) u_sram_bridge (
    .fclk       (fclk),
    .hresetn    (hresetn),
    .bus        (bus),
    .hsel       (hsel_sram),
    .hreadyout  (hreadyout_sram),
    .hrdata     (hrdata_sram),
    .sram_addr  (sram_addr),
    .sram_wen   (sram_wen),
    .sram_wdata (sram_wdata),
    .sram_cs    (sram_cs),
    .sram_rdata (sram_rdata)
  );

  // Memory has no reset
  sram_bank #(.SRAM_ADDR_W(SRAM_ADDR_W)) u_sram_bank (
    .fclk  (fclk),
    .addr  (sram_addr),
    .wen   (sram_wen),
    .cs    (sram_cs),
    .wdata (sram_wdata),
    .rdata (sram_rdata)
  );

  ahb_gpio u_gpio (
    .fclk      (fclk),
    .hresetn   (hresetn),
    .bus       (bus),
    .hsel      (hsel_gpio),
    .hreadyout (hreadyout_gpio),
    .hrdata    (hrdata_gpio),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .gpio_oe   (gpio_oe)
  );

endmodule

//--- testbench/tb_ahb_subsystem.sv
`timescale 1ns/1ps

module tb_ahb_subsystem import ahb_pkg::*; ();

  localparam int MAX_ROWS = 64;

  logic    fclk;
  logic    resetn;
  logic    soft_reset_req;
  haddr_t  haddr;
  htrans_t htrans;
  logic    hwrite;
  hsize_t  hsize;
  hdata_t  hwdata;
  hdata_t  hrdata;
  logic    hready;
  gpio_t   gpio_in;
  gpio_t   gpio_out;
  gpio_t   gpio_oe;

  // ******************************
  // Stimulus table
  // ******************************
  string       t_name  [0:MAX_ROWS-1];
  logic        t_write [0:MAX_ROWS-1];
  haddr_t      t_addr  [0:MAX_ROWS-1];
  hsize_t      t_size  [0:MAX_ROWS-1];
  hdata_t      t_wdata [0:MAX_ROWS-1];
  gpio_t       t_gin   [0:MAX_ROWS-1];
  hdata_t      t_exp   [0:MAX_ROWS-1];
  // Soft reset before the row, with {gpio_oe, gpio_out} expected just before it
  logic        t_srst  [0:MAX_ROWS-1];
  logic [31:0] t_pins  [0:MAX_ROWS-1];
  int          num_rows;

  logic [31:0] lfsr_state;
  hdata_t      fill [0:7];
  int          cycle_count;
  int          timeout_limit;
  int          prev;
  int          waits;

  ahb_subsystem #(.SRAM_ADDR_W(10)) dut (
    .fclk           (fclk),
    .resetn         (resetn),
    .soft_reset_req (soft_reset_req),
    .haddr          (haddr),
    .htrans         (htrans),
    .hwrite         (hwrite),
    .hsize          (hsize),
    .hwdata         (hwdata),
    .hrdata         (hrdata),
    .hready         (hready),
    .gpio_in        (gpio_in),
    .gpio_out       (gpio_out),
    .gpio_oe        (gpio_oe)
  );

  initial begin
    fclk = 1'b0;
    forever #5 fclk = ~fclk;
  end

  // Run limit
  always @(posedge fclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation aborted");
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_word(output logic [31:0] word);
    word = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word = {word[30:0], lfsr_state[0]};
    end
  endtask

  task automatic add_row(input string name, input logic wr, input haddr_t addr,
                         input hsize_t size, input hdata_t wdata, input gpio_t gin,
                         input hdata_t exp, input logic srst, input logic [31:0] pins);
    t_name[num_rows]  = name;
    t_write[num_rows] = wr;
    t_addr[num_rows]  = addr;
    t_size[num_rows]  = size;
    t_wdata[num_rows] = wdata;
    t_gin[num_rows]   = gin;
    t_exp[num_rows]   = exp;
    t_srst[num_rows]  = srst;
    t_pins[num_rows]  = pins;
    num_rows = num_rows + 1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "check mismatch");
    end
  endtask

  // SRAM reads stretch the data phase by one cycle, all else by none
  function automatic int expected_waits(input int idx);
    if (!t_write[idx] && (t_addr[idx] <= SRAM_LIMIT)) begin
      return 1;
    end
    return 0;
  endfunction

  task automatic build_table();
    num_rows = 0;
    // SRAM word access, first read hits the write buffer
    add_row("sram_wr_w0", 1, 32'h0000_0000, HSIZE_WORD, 32'h1122_3344, 16'h0, 0, 0, 0);
    add_row("sram_rd_fwd0", 0, 32'h0000_0000, HSIZE_WORD, 0, 16'h0, 32'h1122_3344, 0, 0);
    add_row("sram_wr_w1", 1, 32'h0000_0040, HSIZE_WORD, 32'hCAFE_F00D, 16'h0, 0, 0, 0);
    add_row("sram_wr_w2", 1, 32'h0000_0FFC, HSIZE_WORD, 32'h0BAD_BEEF, 16'h0, 0, 0, 0);
    add_row("sram_rd_w1", 0, 32'h0000_0040, HSIZE_WORD, 0, 16'h0, 32'hCAFE_F00D, 0, 0);
    add_row("sram_rd_w2", 0, 32'h0000_0FFC, HSIZE_WORD, 0, 16'h0, 32'h0BAD_BEEF, 0, 0);
    // Sub-word lanes, little endian
    add_row("sram_wr_base", 1, 32'h0000_0080, HSIZE_WORD, 32'hA0B1_C2D3, 16'h0, 0, 0, 0);
    add_row("sram_wr_b1", 1, 32'h0000_0081, HSIZE_BYTE, 32'h0000_5500, 16'h0, 0, 0, 0);
    add_row("sram_wr_h2", 1, 32'h0000_0082, HSIZE_HALF, 32'h7788_0000, 16'h0, 0, 0, 0);
    add_row("sram_rd_merge", 0, 32'h0000_0080, HSIZE_WORD, 0, 16'h0, 32'h7788_55D3, 0, 0);
    add_row("sram_wr_b0", 1, 32'h0000_0080, HSIZE_BYTE, 32'h0000_0099, 16'h0, 0, 0, 0);
    add_row("sram_rd_b0", 0, 32'h0000_0080, HSIZE_WORD, 0, 16'h0, 32'h7788_5599, 0, 0);
    // GPIO registers, input applied well ahead of its read
    add_row("gpio_wr_out", 1, 32'h4000_0000, HSIZE_WORD, 32'hFFFF_5A3C, 16'h0, 0, 0, 0);
    add_row("gpio_wr_oe", 1, 32'h4000_0004, HSIZE_WORD, 32'h0000_00FF, 16'hA5C3, 0, 0, 0);
    add_row("gpio_rd_out", 0, 32'h4000_0000, HSIZE_WORD, 0, 16'hA5C3, 32'h0000_5A3C, 0, 0);
    add_row("gpio_rd_oe", 0, 32'h4000_0004, HSIZE_WORD, 0, 16'hA5C3, 32'h0000_00FF, 0, 0);
    add_row("gpio_rd_in", 0, 32'h4000_0008, HSIZE_WORD, 0, 16'hA5C3, 32'h0000_A5C3, 0, 0);
    // Unmapped space
    add_row("nomap_rd", 0, 32'h2000_0000, HSIZE_WORD, 0, 16'hA5C3, 32'h0, 0, 0);
    add_row("nomap_wr_sram", 1, 32'h0001_0000, HSIZE_WORD, 32'hDEAD_DEAD, 16'hA5C3, 0, 0, 0);
    add_row("nomap_wr_gpio", 1, 32'h4000_1000, HSIZE_WORD, 32'h0000_1234, 16'hA5C3, 0, 0, 0);
    add_row("nomap_chk_sram", 0, 32'h0000_0000, HSIZE_WORD, 0, 16'hA5C3, 32'h1122_3344, 0, 0);
    add_row("nomap_chk_gpio", 0, 32'h4000_0000, HSIZE_WORD, 0, 16'hA5C3, 32'h0000_5A3C, 0, 0);
    // 4 KB SRAM aliases through the 64 KB window
    add_row("sram_rd_alias", 0, 32'h0000_1000, HSIZE_WORD, 0, 16'hA5C3, 32'h1122_3344, 0, 0);
    // Soft reset clears GPIO, memory survives
    add_row("srst_rd_out", 0, 32'h4000_0000, HSIZE_WORD, 0, 16'hA5C3, 32'h0, 1,
            32'h00FF_5A3C);
    add_row("srst_rd_oe", 0, 32'h4000_0004, HSIZE_WORD, 0, 16'hA5C3, 32'h0, 0, 0);
    add_row("srst_rd_sram", 0, 32'h0000_0040, HSIZE_WORD, 0, 16'hA5C3, 32'hCAFE_F00D, 0, 0);
    // Pipelined run with LFSR data
    for (int k = 0; k < 8; k++) begin
      take_word(fill[k]);
      add_row($sformatf("pipe_wr_%0d", k), 1, 32'h0000_0100 + 4 * k, HSIZE_WORD,
              fill[k], 16'hA5C3, 0, 0, 0);
    end
    for (int k = 0; k < 8; k++) begin
      add_row($sformatf("pipe_rd_%0d", k), 0, 32'h0000_0100 + 4 * k, HSIZE_WORD,
              0, 16'hA5C3, fill[k], 0, 0);
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    resetn         = 1'b0;
    soft_reset_req = 1'b0;
    haddr          = '0;
    htrans         = HTRANS_IDLE;
    hwrite         = 1'b0;
    hsize          = HSIZE_WORD;
    hwdata         = '0;
    gpio_in        = '0;
    cycle_count    = 0;
    lfsr_state     = 32'hf6810f7e;
    build_table();
    timeout_limit  = 4 * num_rows + 10 + 200;

    repeat (10) @(negedge fclk);
    resetn = 1'b1;
    // Bus reset leaves the synchronizer three cycles later
    repeat (5) @(negedge fclk);

    prev = -1;
    for (int i = 0; i <= num_rows; i++) begin
      @(negedge fclk);
      // Stretched data phase of the previous row
      waits = 0;
      while (!hready) begin
        waits = waits + 1;
        @(negedge fclk);
      end
      if (prev >= 0) begin
        check_value({t_name[prev], "_waits"}, 32'(expected_waits(prev)), 32'(waits));
        if (!t_write[prev]) begin
          check_value(t_name[prev], t_exp[prev], hrdata);
        end
      end
      // Write data follows its address by one cycle
      hwdata = (prev >= 0) ? t_wdata[prev] : '0;
      if (i == num_rows) begin
        htrans = HTRANS_IDLE;
      end else begin
        if (t_srst[i]) begin
          htrans = HTRANS_IDLE;
          @(negedge fclk);
          check_value({t_name[i], "_pins_before"}, t_pins[i], {gpio_oe, gpio_out});
          soft_reset_req = 1'b1;
          repeat (3) @(negedge fclk);
          check_value({t_name[i], "_pins_after"}, 32'h0, {gpio_oe, gpio_out});
          soft_reset_req = 1'b0;
          repeat (4) @(negedge fclk);
        end
        haddr   = t_addr[i];
        htrans  = HTRANS_NONSEQ;
        hwrite  = t_write[i];
        hsize   = t_size[i];
        gpio_in = t_gin[i];
        prev    = i;
      end
    end

    repeat (2) @(negedge fclk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verilog.f
common/ahb_pkg.sv
common/ahb_if.sv
logic/ahb_decoder.sv
logic/ahb_resp_mux.sv
sram/ahb_sram_bridge.sv
sram/sram_bank.sv
gpio/ahb_gpio.sv
logic/ahb_subsystem.sv
testbench/tb_ahb_subsystem.sv
